// File: hdl/periph_pkg.sv
// Shared widths, word types and register indices
// for the AXI-lite CPU peripheral block
package periph_pkg;

	// Bus geometry
	localparam int ADDR_W    = 6;
	localparam int DATA_W    = 32;
	localparam int ADDR_LSB  = 2;
	localparam int REG_IDX_W = 4;

	typedef logic [DATA_W-1:0]   word_t;
	typedef logic [DATA_W/8-1:0] strb_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Word indices, anything else is reserved
	localparam reg_idx_t REG_PIC      = 4'd0;
	localparam reg_idx_t REG_TMRA     = 4'd4;
	localparam reg_idx_t REG_TMRB     = 4'd5;
	localparam reg_idx_t REG_TMRC     = 4'd6;
	localparam reg_idx_t REG_CNT_BASE = 4'd8;
	localparam reg_idx_t REG_CLOCKS   = 4'd8;
	localparam reg_idx_t REG_OPSTALL  = 4'd9;
	localparam reg_idx_t REG_PFSTALL  = 4'd10;
	localparam reg_idx_t REG_ICOUNT   = 4'd11;

	localparam int N_TIMERS   = 3;
	localparam int N_COUNTERS = 4;

	// Interrupt controller word layout
	localparam int MAX_INTS        = 15;
	localparam int AUTO_RELOAD_BIT = 31;
	localparam int PIC_ENABLE_LSB  = 16;
	localparam int PIC_MASTER_BIT  = 31;
	localparam int PIC_ACTIVE_BIT  = 15;

endpackage

// File: hdl/reg_write_if.sv
// Decoded register write, from the AXI-lite write port
// to the interrupt controller, timers and counters
`timescale 1ns/1ns

interface reg_write_if;

	logic                 wr_stb;
	periph_pkg::reg_idx_t wr_idx;
	periph_pkg::word_t    wr_data;
	periph_pkg::strb_t    wr_strb;

	// Write port side
	modport source (output wr_stb, wr_idx, wr_data, wr_strb);

	// Register side, acts on wr_stb when wr_idx matches
	modport sink (input wr_stb, wr_idx, wr_data, wr_strb);

endinterface

// File: hdl/axil_write_port.sv
// AXI-lite write address, write data and write response channels,
// plus the one-cycle register write strobe
`timescale 1ns/1ns

module axil_write_port (
	input  logic                            S_AXI_ACLK,
	input  logic                            i_cpu_reset,
	input  logic                            i_awvalid,
	input  logic [periph_pkg::ADDR_W-1:0]   i_awaddr,
	input  logic                            i_wvalid,
	input  periph_pkg::word_t               i_wdata,
	input  periph_pkg::strb_t               i_wstrb,
	input  logic                            i_bready,
	output logic                            o_awready,
	output logic                            o_wready,
	output logic                            o_bvalid,
	output logic [1:0]                      o_bresp,
	reg_write_if.source                     o_wr
);

	logic axil_awready;

	////////////////////
	// Write acceptance
	////////////////////

	// Address and data go together, one beat at a time.
	// Held off while a response is still waiting on BREADY
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			axil_awready <= 1'b0;
		else
			axil_awready <= !axil_awready && i_awvalid && i_wvalid
				&& (!o_bvalid || i_bready);
	end

	assign o_awready = axil_awready;
	assign o_wready  = axil_awready;

	// Present the accepted beat to the registers
	assign o_wr.wr_stb  = axil_awready;
	assign o_wr.wr_idx  = i_awaddr[periph_pkg::ADDR_W-1:periph_pkg::ADDR_LSB];
	assign o_wr.wr_data = i_wdata;
	assign o_wr.wr_strb = i_wstrb;

	////////////////////
	// Write response
	////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			o_bvalid <= 1'b0;
		else if (axil_awready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	// Always OKAY
	assign o_bresp = 2'b00;

endmodule

// File: hdl/int_controller.sv
// Primary interrupt controller: status latches, per-source enables,
// master enable and the registered interrupt output
`timescale 1ns/1ns

module int_controller #(
	parameter int N_INTS = 5
) (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	reg_write_if.sink         i_wr,
	input  logic [N_INTS-1:0] i_ints,
	output periph_pkg::word_t o_word,
	output logic              o_interrupt
);

	localparam int EN_LSB = periph_pkg::PIC_ENABLE_LSB;
	localparam int MI     = periph_pkg::MAX_INTS;

	logic              pic_hit;
	logic [N_INTS-1:0] status;
	logic [N_INTS-1:0] enables;
	logic              master_en;
	logic              active;
	logic [N_INTS-1:0] clr_field;
	logic [N_INTS-1:0] en_field;
	logic [MI-1:0]     status_w;
	logic [MI-1:0]     enable_w;

	assign pic_hit   = i_wr.wr_stb && (i_wr.wr_idx == periph_pkg::REG_PIC);
	assign clr_field = i_wr.wr_data[N_INTS-1:0];
	assign en_field  = i_wr.wr_data[EN_LSB +: N_INTS];

	// Status. A new input wins over a clear in the same cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			status <= '0;
		else if (pic_hit)
			status <= (status & ~clr_field) | i_ints;
		else
			status <= status | i_ints;
	end

	////////////////////
	// Enables
	////////////////////

	// Master bit set: turn on master and listed enables.
	// Master bit clear: drop listed enables, or master if none listed
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset) begin
			enables   <= '0;
			master_en <= 1'b0;
		end else if (pic_hit) begin
			if (i_wr.wr_data[periph_pkg::PIC_MASTER_BIT]) begin
				master_en <= 1'b1;
				enables   <= enables | en_field;
			end else if (|en_field) begin
				enables <= enables & ~en_field;
			end else begin
				master_en <= 1'b0;
			end
		end
	end

	assign active = |(status & enables);

	// Pad both fields out to the full controller width
	always_comb begin
		status_w = '0;
		enable_w = '0;
		status_w[N_INTS-1:0] = status;
		enable_w[N_INTS-1:0] = enables;
	end

	always_comb begin
		o_word = '0;
		o_word[MI-1:0]                      = status_w;
		o_word[periph_pkg::PIC_ACTIVE_BIT]  = active;
		o_word[EN_LSB +: MI]                = enable_w;
		o_word[periph_pkg::PIC_MASTER_BIT]  = master_en;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			o_interrupt <= 1'b0;
		else
			o_interrupt <= master_en && active;
	end

endmodule

// File: hdl/interval_timer.sv
// Down-counting interval timer with optional auto-reload
// and a one-cycle terminal-count interrupt
`timescale 1ns/1ns

module interval_timer #(
	parameter periph_pkg::reg_idx_t REG_ADDR = periph_pkg::REG_TMRA
) (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	input  logic              i_run,
	reg_write_if.sink         i_wr,
	output periph_pkg::word_t o_word,
	output logic              o_int
);

	localparam int CNT_W = periph_pkg::AUTO_RELOAD_BIT;

	logic             tmr_hit;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] reload;
	logic             auto_reload;

	assign tmr_hit = i_wr.wr_stb && (i_wr.wr_idx == REG_ADDR);

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset) begin
			count       <= '0;
			reload      <= '0;
			auto_reload <= 1'b0;
			o_int       <= 1'b0;
		end else begin
			o_int <= 1'b0;
			if (tmr_hit) begin
				// Full word load, reload only kept with the flag set
				count       <= i_wr.wr_data[CNT_W-1:0];
				auto_reload <= i_wr.wr_data[periph_pkg::AUTO_RELOAD_BIT];
				if (i_wr.wr_data[periph_pkg::AUTO_RELOAD_BIT])
					reload <= i_wr.wr_data[CNT_W-1:0];
				else
					reload <= '0;
			end else if (i_run && (count != '0)) begin
				if (count == CNT_W'(1)) begin
					// Terminal count
					count <= reload;
					o_int <= 1'b1;
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

	assign o_word = {auto_reload, count};

endmodule

// File: hdl/perf_counters.sv
// Supervisor performance counters: clocks, operand stalls,
// prefetch stalls and retired instructions, with byte-strobed presets
`timescale 1ns/1ns

module perf_counters (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	input  logic              i_run,
	input  logic              i_opstall,
	input  logic              i_pfstall,
	input  logic              i_icount,
	reg_write_if.sink         i_wr,
	output periph_pkg::word_t [periph_pkg::N_COUNTERS-1:0] o_words
);

	logic [periph_pkg::N_COUNTERS-1:0] events;

	// Event order follows the register order from REG_CNT_BASE
	assign events = {i_icount, i_pfstall, i_opstall, i_run};

	// Replace only the strobed byte lanes
	function automatic periph_pkg::word_t apply_strb(
		input periph_pkg::word_t prior,
		input periph_pkg::word_t data,
		input periph_pkg::strb_t strb
	);
		periph_pkg::word_t result;

		for (int k = 0; k < periph_pkg::DATA_W/8; k++) begin
			result[k*8 +: 8] = strb[k] ? data[k*8 +: 8] : prior[k*8 +: 8];
		end
		return result;
	endfunction

	////////////////////
	// One counter per event
	////////////////////

	for (genvar i = 0; i < periph_pkg::N_COUNTERS; i++) begin : g_cnt
		localparam periph_pkg::reg_idx_t IDX =
			periph_pkg::reg_idx_t'(periph_pkg::REG_CNT_BASE + i);

		logic cnt_hit;

		assign cnt_hit = i_wr.wr_stb && (i_wr.wr_idx == IDX);

		// Preset beats the increment
		always_ff @(posedge S_AXI_ACLK) begin
			if (i_cpu_reset)
				o_words[i] <= '0;
			else if (cnt_hit)
				o_words[i] <= apply_strb(o_words[i], i_wr.wr_data, i_wr.wr_strb);
			else if (events[i])
				o_words[i] <= o_words[i] + 1'b1;
		end
	end

endmodule

// File: hdl/axil_read_port.sv
// AXI-lite read address acceptance, register read multiplexer
// and the read data channel
`timescale 1ns/1ns

module axil_read_port (
	input  logic                                          S_AXI_ACLK,
	input  logic                                          i_cpu_reset,
	input  logic                                          i_arvalid,
	input  logic [periph_pkg::ADDR_W-1:0]                 i_araddr,
	input  logic                                          i_rready,
	input  periph_pkg::word_t                             i_pic_word,
	input  periph_pkg::word_t [periph_pkg::N_TIMERS-1:0]   i_timer_words,
	input  periph_pkg::word_t [periph_pkg::N_COUNTERS-1:0] i_count_words,
	output logic                                          o_arready,
	output logic                                          o_rvalid,
	output periph_pkg::word_t                             o_rdata,
	output logic [1:0]                                    o_rresp
);

	periph_pkg::reg_idx_t rd_idx;
	periph_pkg::word_t    sel_word;
	logic                 rd_accept;

	// One read in flight at most
	assign o_arready = !o_rvalid;
	assign rd_accept = i_arvalid && o_arready;
	assign rd_idx    = i_araddr[periph_pkg::ADDR_W-1:periph_pkg::ADDR_LSB];

	////////////////////
	// Register select
	////////////////////

	always_comb begin
		case (rd_idx)
			periph_pkg::REG_PIC:     sel_word = i_pic_word;
			periph_pkg::REG_TMRA:    sel_word = i_timer_words[0];
			periph_pkg::REG_TMRB:    sel_word = i_timer_words[1];
			periph_pkg::REG_TMRC:    sel_word = i_timer_words[2];
			periph_pkg::REG_CLOCKS:  sel_word = i_count_words[0];
			periph_pkg::REG_OPSTALL: sel_word = i_count_words[1];
			periph_pkg::REG_PFSTALL: sel_word = i_count_words[2];
			periph_pkg::REG_ICOUNT:  sel_word = i_count_words[3];
			// Reserved
			default:                 sel_word = '0;
		endcase
	end

	////////////////////
	// Read data channel
	////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			o_rvalid <= 1'b0;
		else if (rd_accept)
			o_rvalid <= 1'b1;
		else if (i_rready)
			o_rvalid <= 1'b0;
	end

	// Data only moves on accept, so it holds through back-pressure
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			o_rdata <= '0;
		else if (rd_accept)
			o_rdata <= sel_word;
	end

	assign o_rresp = 2'b00;

endmodule

// File: hdl/periph_top.sv
// Peripheral block top level: AXI-lite ports, interrupt controller,
// three interval timers and the supervisor performance counters
`timescale 1ns/1ns

module periph_top #(
	parameter int N_EXT_INTS = 2
) (
	input  logic                          S_AXI_ACLK,
	input  logic                          i_cpu_reset,
	// AXI-lite slave
	input  logic                          S_AXI_AWVALID,
	output logic                          S_AXI_AWREADY,
	input  logic [periph_pkg::ADDR_W-1:0] S_AXI_AWADDR,
	input  logic                          S_AXI_WVALID,
	output logic                          S_AXI_WREADY,
	input  periph_pkg::word_t             S_AXI_WDATA,
	input  periph_pkg::strb_t             S_AXI_WSTRB,
	output logic                          S_AXI_BVALID,
	input  logic                          S_AXI_BREADY,
	output logic [1:0]                    S_AXI_BRESP,
	input  logic                          S_AXI_ARVALID,
	output logic                          S_AXI_ARREADY,
	input  logic [periph_pkg::ADDR_W-1:0] S_AXI_ARADDR,
	output logic                          S_AXI_RVALID,
	input  logic                          S_AXI_RREADY,
	output periph_pkg::word_t             S_AXI_RDATA,
	output logic [1:0]                    S_AXI_RRESP,
	// CPU status
	input  logic                          i_cpu_halted,
	input  logic                          i_cpu_opstall,
	input  logic                          i_cpu_pfstall,
	input  logic                          i_cpu_icount,
	input  logic [N_EXT_INTS-1:0]         i_ext_ints,
	output logic                          o_interrupt
);

	localparam int N_INTS = periph_pkg::N_TIMERS + N_EXT_INTS;

	periph_pkg::word_t                             pic_word;
	periph_pkg::word_t [periph_pkg::N_TIMERS-1:0]   timer_words;
	periph_pkg::word_t [periph_pkg::N_COUNTERS-1:0] count_words;
	logic [periph_pkg::N_TIMERS-1:0]               timer_ints;
	logic [N_INTS-1:0]                             int_vector;
	logic                                          cpu_run;

	reg_write_if wr_bus ();

	// Timers and clock counter freeze while halted
	assign cpu_run = !i_cpu_halted;

	// Timers in the low bits, external sources above
	assign int_vector = {i_ext_ints, timer_ints};

	axil_write_port u_wr_port (
		.S_AXI_ACLK (S_AXI_ACLK),   .i_cpu_reset(i_cpu_reset),
		.i_awvalid  (S_AXI_AWVALID), .i_awaddr  (S_AXI_AWADDR),
		.i_wvalid   (S_AXI_WVALID),  .i_wdata   (S_AXI_WDATA),
		.i_wstrb    (S_AXI_WSTRB),   .i_bready  (S_AXI_BREADY),
		.o_awready  (S_AXI_AWREADY), .o_wready  (S_AXI_WREADY),
		.o_bvalid   (S_AXI_BVALID),  .o_bresp   (S_AXI_BRESP),
		.o_wr       (wr_bus.source)
	);

	int_controller #(.N_INTS(N_INTS)) u_pic (
		.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(i_cpu_reset),
		.i_wr(wr_bus.sink), .i_ints(int_vector),
		.o_word(pic_word), .o_interrupt(o_interrupt)
	);

	////////////////////
	// Timers
	////////////////////

	interval_timer #(.REG_ADDR(periph_pkg::REG_TMRA)) u_tmr_a (
		.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(i_cpu_reset), .i_run(cpu_run),
		.i_wr(wr_bus.sink), .o_word(timer_words[0]), .o_int(timer_ints[0])
	);

	interval_timer #(.REG_ADDR(periph_pkg::REG_TMRB)) u_tmr_b (
		.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(i_cpu_reset), .i_run(cpu_run),
		.i_wr(wr_bus.sink), .o_word(timer_words[1]), .o_int(timer_ints[1])
	);

	interval_timer #(.REG_ADDR(periph_pkg::REG_TMRC)) u_tmr_c (
		.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(i_cpu_reset), .i_run(cpu_run),
		.i_wr(wr_bus.sink), .o_word(timer_words[2]), .o_int(timer_ints[2])
	);

	perf_counters u_counters (
		.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(i_cpu_reset),
		.i_run(cpu_run), .i_opstall(i_cpu_opstall),
		.i_pfstall(i_cpu_pfstall), .i_icount(i_cpu_icount),
		.i_wr(wr_bus.sink), .o_words(count_words)
	);

	axil_read_port u_rd_port (
		.S_AXI_ACLK   (S_AXI_ACLK),    .i_cpu_reset(i_cpu_reset),
		.i_arvalid    (S_AXI_ARVALID), .i_araddr   (S_AXI_ARADDR),
		.i_rready     (S_AXI_RREADY),  .i_pic_word (pic_word),
		.i_timer_words(timer_words),   .i_count_words(count_words),
		.o_arready    (S_AXI_ARREADY), .o_rvalid   (S_AXI_RVALID),
		.o_rdata      (S_AXI_RDATA),   .o_rresp    (S_AXI_RRESP)
	);

endmodule

// File: bench/tb_axil_tasks.svh
// AXI-lite single-beat write and read tasks for the testbench
// Inputs change on the rising edge, outputs are sampled on the falling edge
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

task automatic axil_write(
	input periph_pkg::reg_idx_t idx,
	input periph_pkg::word_t    data,
	input periph_pkg::strb_t    strb
);
	int n;

	@(posedge S_AXI_ACLK);
	awvalid <= 1'b1;
	awaddr  <= {idx, 2'b00};
	wvalid  <= 1'b1;
	wdata   <= data;
	wstrb   <= strb;
	for (n = 0; n < TIMEOUT_CYCLES; n++) begin
		@(negedge S_AXI_ACLK);
		if (awready)
			break;
	end
	if (!awready)
		stop_on_timeout("write address and data were never accepted");
	// Data channel is taken in the same beat as the address
	check_word("write_ready", 32'h1, wready);
	@(posedge S_AXI_ACLK);
	awvalid <= 1'b0;
	wvalid  <= 1'b0;
	// BREADY stays high, so the response lasts one cycle
	for (n = 0; n < TIMEOUT_CYCLES; n++) begin
		@(negedge S_AXI_ACLK);
		if (bvalid)
			break;
	end
	if (!bvalid)
		stop_on_timeout("no write response arrived");
	check_word("write_resp", 32'h0, bresp);
endtask

// A stall above zero holds RREADY low for that many cycles after RVALID
task automatic axil_read(
	input  periph_pkg::reg_idx_t idx,
	input  int                   stall,
	output periph_pkg::word_t    data,
	output bit                   held
);
	int n;

	@(posedge S_AXI_ACLK);
	arvalid <= 1'b1;
	araddr  <= {idx, 2'b00};
	if (stall > 0)
		rready <= 1'b0;
	for (n = 0; n < TIMEOUT_CYCLES; n++) begin
		@(negedge S_AXI_ACLK);
		if (arready)
			break;
	end
	if (!arready)
		stop_on_timeout("read address was never accepted");
	@(posedge S_AXI_ACLK);
	if (stall > 0) begin
		// Next request to another word waits behind the stalled response
		araddr <= {~idx, 2'b00};
	end else begin
		arvalid <= 1'b0;
	end
	for (n = 0; n < TIMEOUT_CYCLES; n++) begin
		@(negedge S_AXI_ACLK);
		if (rvalid)
			break;
	end
	if (!rvalid)
		stop_on_timeout("read data never became valid");
	check_word("read_resp", 32'h0, rresp);
	data = rdata;
	held = 1'b1;
	for (n = 0; n < stall; n++) begin
		@(negedge S_AXI_ACLK);
		if (!rvalid || rdata !== data)
			held = 1'b0;
	end
	if (stall > 0) begin
		@(posedge S_AXI_ACLK);
		rready  <= 1'b1;
		arvalid <= 1'b0;
	end
	for (n = 0; n < TIMEOUT_CYCLES; n++) begin
		@(negedge S_AXI_ACLK);
		if (!rvalid)
			break;
	end
	if (rvalid)
		stop_on_timeout("read data stayed valid after RREADY");
endtask

`endif

// File: bench/tb_periph.sv
// Testbench for the AXI-lite peripheral block
// Timer load, counter presets, counting, interrupts, reserved reads
`timescale 1ns/1ns

module tb_periph;

	localparam int          CLK_HALF       = 2;
	localparam int          RESET_CYCLES   = 16;
	localparam int          TIMEOUT_CYCLES = 200;
	localparam logic [31:0] RNG_SEED       = 32'hdda6cdf0;

	logic                          S_AXI_ACLK = 1'b0;
	logic                          i_cpu_reset;
	logic                          awvalid, wvalid, bready, arvalid, rready;
	logic [periph_pkg::ADDR_W-1:0] awaddr, araddr;
	periph_pkg::word_t             wdata, rdata;
	periph_pkg::strb_t             wstrb;
	logic                          awready, wready, bvalid, arready, rvalid;
	logic [1:0]                    bresp, rresp;
	logic                          cpu_halted, cpu_opstall, cpu_pfstall, cpu_icount;
	logic [1:0]                    ext_ints;
	logic                          o_interrupt;
	int                            test_errs, n_checks, n_fails;

	always #CLK_HALF S_AXI_ACLK = ~S_AXI_ACLK;

	periph_top #(.N_EXT_INTS(2)) uut (
		.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(i_cpu_reset),
		.S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready), .S_AXI_AWADDR(awaddr),
		.S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready), .S_AXI_WDATA(wdata),
		.S_AXI_WSTRB(wstrb), .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
		.S_AXI_BRESP(bresp), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
		.S_AXI_ARADDR(araddr), .S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
		.S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.i_cpu_halted(cpu_halted), .i_cpu_opstall(cpu_opstall),
		.i_cpu_pfstall(cpu_pfstall), .i_cpu_icount(cpu_icount),
		.i_ext_ints(ext_ints), .o_interrupt(o_interrupt)
	);

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Test FAILED");
		$finish;
	endtask

	`include "tb_axil_tasks.svh"

	////////////////////
	// Reference model
	////////////////////

	// Reload flag on top of the 31-bit count
	function automatic periph_pkg::word_t timer_expect(input periph_pkg::word_t w);
		return {w[periph_pkg::AUTO_RELOAD_BIT], w[periph_pkg::AUTO_RELOAD_BIT-1:0]};
	endfunction

	function automatic periph_pkg::word_t strb_merge(
		input periph_pkg::word_t prior,
		input periph_pkg::word_t data,
		input periph_pkg::strb_t strb
	);
		periph_pkg::word_t mask;

		mask = '0;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				mask = mask | (32'hff << (8 * b));
		end
		return (prior & ~mask) | (data & mask);
	endfunction

	// Controller word from master, enable and status fields
	function automatic periph_pkg::word_t pic_expect(
		input logic        master,
		input logic [14:0] en,
		input logic [14:0] st
	);
		periph_pkg::word_t w;

		w = '0;
		w[14:0] = st;
		w[periph_pkg::PIC_ACTIVE_BIT] = |(en & st);
		w[periph_pkg::PIC_ENABLE_LSB +: 15] = en;
		w[periph_pkg::PIC_MASTER_BIT] = master;
		return w;
	endfunction

	task automatic check_word(
		input string             name,
		input periph_pkg::word_t exp,
		input periph_pkg::word_t act
	);
		n_checks++;
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
			$display("[PASS] %s", name);
		else
			$display("[DONE] %s with %0d errors", name, test_errs);
		n_fails += test_errs;
		test_errs = 0;
	endtask

	task automatic wait_interrupt(input logic level, input string what);
		int n;

		for (n = 0; n < TIMEOUT_CYCLES; n++) begin
			@(negedge S_AXI_ACLK);
			if (o_interrupt === level)
				break;
		end
		if (o_interrupt !== level)
			stop_on_timeout(what);
	endtask

	task automatic set_halted(input logic level);
		@(posedge S_AXI_ACLK);
		cpu_halted <= level;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		periph_pkg::word_t    w, rd, prior, c1, c2;
		periph_pkg::strb_t    strb;
		periph_pkg::reg_idx_t idx;
		periph_pkg::reg_idx_t reserved_idx [8];
		bit                   held;
		int                   span, stall;

		void'($urandom(RNG_SEED));
		reserved_idx = '{4'd1, 4'd2, 4'd3, 4'd7, 4'd12, 4'd13, 4'd14, 4'd15};
		test_errs = 0;
		n_checks  = 0;
		n_fails   = 0;
		i_cpu_reset = 1'b1;
		{awvalid, wvalid, arvalid} = 3'b000;
		bready  = 1'b1;
		rready  = 1'b1;
		awaddr  = '0;
		araddr  = '0;
		wdata   = '0;
		wstrb   = '0;
		cpu_halted  = 1'b1;
		{cpu_opstall, cpu_pfstall, cpu_icount} = 3'b000;
		ext_ints = '0;
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		i_cpu_reset <= 1'b0;

		// Timer load readback, halted so nothing counts
		for (int t = 0; t < periph_pkg::N_TIMERS; t++) begin
			idx = periph_pkg::reg_idx_t'(periph_pkg::REG_TMRA + t);
			w = $urandom;
			axil_write(idx, w, 4'hf);
			axil_read(idx, 0, rd, held);
			check_word($sformatf("timer_load[%0d]", t), timer_expect(w), rd);
			axil_write(idx, 32'h0, 4'hf);
		end
		finish_test("timer_load");

		// Counter byte strobes
		for (int k = 0; k < 6; k++) begin
			idx = periph_pkg::reg_idx_t'(periph_pkg::REG_CNT_BASE + $urandom_range(3, 0));
			axil_read(idx, 0, prior, held);
			w = $urandom;
			strb = periph_pkg::strb_t'($urandom_range(15, 0));
			axil_write(idx, w, strb);
			axil_read(idx, 0, rd, held);
			check_word($sformatf("counter_strobes[%0d]", idx), strb_merge(prior, w, strb), rd);
		end
		finish_test("counter_strobes");

		// Clock counter runs only while not halted
		axil_write(periph_pkg::REG_CLOCKS, 32'h0, 4'hf);
		span = 20 + $urandom_range(15, 0);
		set_halted(1'b0);
		repeat (span) @(posedge S_AXI_ACLK);
		cpu_halted <= 1'b1;
		axil_read(periph_pkg::REG_CLOCKS, 0, c1, held);
		repeat (10) @(posedge S_AXI_ACLK);
		axil_read(periph_pkg::REG_CLOCKS, 0, c2, held);
		n_checks += 2;
		if (c1 < span) begin
			$display("[FAIL] counting expected at least %0d actual %0d", span, c1);
			test_errs++;
		end
		if (c2 !== c1) begin
			$display("[FAIL] counting_halted expected %h actual %h", c1, c2);
			test_errs++;
		end
		finish_test("counting");

		// Timer A raises its interrupt
		axil_write(periph_pkg::REG_PIC, 32'h0000_7fff, 4'hf);
		axil_write(periph_pkg::REG_PIC, 32'h8001_0000, 4'hf);
		axil_write(periph_pkg::REG_TMRA, 32'd5, 4'hf);
		set_halted(1'b0);
		wait_interrupt(1'b1, "timer A interrupt never raised");
		set_halted(1'b1);
		axil_read(periph_pkg::REG_PIC, 0, rd, held);
		check_word("timer_interrupt_pic", pic_expect(1'b1, 15'h0001, 15'h0001), rd);
		// Master bit kept so the enables stay as they are
		axil_write(periph_pkg::REG_PIC, 32'h8000_0001, 4'hf);
		wait_interrupt(1'b0, "interrupt did not fall after status clear");
		finish_test("timer_interrupt");

		// External source 0 sits at vector bit 3
		axil_write(periph_pkg::REG_PIC, 32'h0001_0000, 4'hf);
		axil_write(periph_pkg::REG_PIC, 32'h8008_0000, 4'hf);
		@(posedge S_AXI_ACLK);
		ext_ints <= 2'b01;
		@(posedge S_AXI_ACLK);
		ext_ints <= 2'b00;
		wait_interrupt(1'b1, "external interrupt never raised");
		axil_write(periph_pkg::REG_PIC, 32'h0000_0000, 4'hf);
		wait_interrupt(1'b0, "interrupt did not fall after master disable");
		axil_read(periph_pkg::REG_PIC, 0, rd, held);
		check_word("ext_interrupt_pic", pic_expect(1'b0, 15'h0008, 15'h0008), rd);
		finish_test("ext_interrupt");

		// Reserved words, then a read under back-pressure
		foreach (reserved_idx[k]) begin
			axil_read(reserved_idx[k], 0, rd, held);
			check_word($sformatf("unmapped[%0d]", reserved_idx[k]), 32'h0, rd);
		end
		stall = $urandom_range(8, 1);
		axil_read(periph_pkg::REG_PIC, stall, rd, held);
		check_word("backpressure_data", pic_expect(1'b0, 15'h0008, 15'h0008), rd);
		n_checks++;
		if (!held) begin
			$display("Read data changed while RREADY was held low for %0d cycles", stall);
			test_errs++;
		end
		finish_test("unmapped_backpressure");

		$display("Checks run %0d, failures %0d", n_checks, n_fails);
		if (n_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+bench
hdl/periph_pkg.sv
hdl/reg_write_if.sv
hdl/axil_write_port.sv
hdl/int_controller.sv
hdl/interval_timer.sv
hdl/perf_counters.sv
hdl/axil_read_port.sv
hdl/periph_top.sv
bench/tb_periph.sv
